// File: riscv_pkg.sv
package riscv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B    // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4        // link value for jal
    } wb_sel_e;

    // rv32i opcodes used by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [11:0] TOHOST_CSR = 12'h51e;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     pc4;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd;
        xlen_t     imm;
        alu_op_e   alu_op;
        logic      b_is_imm;
        logic      is_branch;
        logic      br_ne;      // bne when set, beq otherwise
        logic      is_jal;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      csr_write;
        wb_sel_e   wb_sel;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        xlen_t     alu_result;
        xlen_t     pc4;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_e   wb_sel;
        logic      csr_write;
        xlen_t     csr_data;
        logic      valid;
    } ex_wb_t;

endpackage

// File: dmem_if.sv
interface dmem_if;
    import riscv_pkg::*;

    xlen_t      addr;     // byte address
    xlen_t      wdata;
    logic [3:0] wbe;      // nonzero means write this edge
    xlen_t      rdata;    // valid one cycle after addr

    modport core (output addr, output wdata, output wbe, input rdata);

    modport memory (input addr, input wdata, input wbe, output rdata);

endinterface

// File: fetch_stage.sv
module fetch_stage #(
    parameter riscv_pkg::xlen_t RESET_PC   = 32'h0000_0000,
    parameter int               IMEM_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          redirect_i,
    input  riscv_pkg::xlen_t              redirect_pc_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  riscv_pkg::xlen_t              imem_wdata_i,
    output riscv_pkg::xlen_t              inst_o,
    output riscv_pkg::xlen_t              pc_o,
    output logic                          inst_valid_o
);
    import riscv_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    xlen_t imem [IMEM_DEPTH];
    xlen_t pc_q;      // address being fetched
    xlen_t pc_next;
    logic  valid_q;

    assign pc_next = redirect_i ? redirect_pc_i : pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_next;
            valid_q <= !redirect_i;   // drop the word fetched behind a taken transfer
        end
    end

    // loader port and registered read share one array
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
        inst_o <= imem[pc_q[AW+1:2]];
        pc_o   <= pc_q;
    end

    assign inst_valid_o = valid_q;

endmodule

// File: decode_stage.sv
module decode_stage (
    input  riscv_pkg::xlen_t     inst_i,
    input  riscv_pkg::xlen_t     pc_i,
    input  logic                 inst_valid_i,
    input  riscv_pkg::xlen_t     rs1_data_i,
    input  riscv_pkg::xlen_t     rs2_data_i,
    output riscv_pkg::reg_addr_t rs1_addr_o,
    output riscv_pkg::reg_addr_t rs2_addr_o,
    output riscv_pkg::id_ex_t    dec_o
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    logic       supported;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        dec_o          = '0;
        dec_o.pc       = pc_i;
        dec_o.pc4      = pc_i + 32'd4;
        dec_o.rs1_data = rs1_data_i;
        dec_o.rs2_data = rs2_data_i;
        dec_o.rs1_addr = rs1_addr_o;
        dec_o.rs2_addr = rs2_addr_o;
        dec_o.rd       = inst_i[11:7];
        supported      = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec_o.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
                    {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
                    default:         supported    = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin   // addi only
                supported       = (funct3 == 3'b000);
                dec_o.imm       = imm_i;
                dec_o.b_is_imm  = 1'b1;
                dec_o.reg_write = 1'b1;
            end
            OPC_LUI: begin
                dec_o.imm       = imm_u;
                dec_o.b_is_imm  = 1'b1;
                dec_o.alu_op    = ALU_PASS_B;
                dec_o.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                supported       = (funct3 == 3'b010);
                dec_o.imm       = imm_i;
                dec_o.b_is_imm  = 1'b1;
                dec_o.mem_read  = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.wb_sel    = WB_MEM;
            end
            OPC_STORE: begin
                supported       = (funct3 == 3'b010);
                dec_o.imm       = imm_s;
                dec_o.b_is_imm  = 1'b1;
                dec_o.mem_write = 1'b1;
            end
            OPC_BRANCH: begin   // beq and bne
                supported       = (funct3[2:1] == 2'b00);
                dec_o.imm       = imm_b;
                dec_o.is_branch = 1'b1;
                dec_o.br_ne     = funct3[0];
            end
            OPC_JAL: begin
                dec_o.imm       = imm_j;
                dec_o.is_jal    = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.wb_sel    = WB_PC4;
            end
            OPC_SYSTEM: begin
                // csrw to tohost, anything else is dropped
                supported       = (funct3 == 3'b001) && (inst_i[31:20] == TOHOST_CSR);
                dec_o.csr_write = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        if (supported && inst_valid_i) begin
            dec_o.valid = 1'b1;
        end else begin
            dec_o = '0;
        end
    end

endmodule

// File: regfile_1w2r.sv
module regfile_1w2r (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  riscv_pkg::reg_addr_t waddr_i,
    input  riscv_pkg::xlen_t     wdata_i,
    input  riscv_pkg::reg_addr_t raddr1_i,
    input  riscv_pkg::reg_addr_t raddr2_i,
    output riscv_pkg::xlen_t     rdata1_o,
    output riscv_pkg::xlen_t     rdata2_o
);
    import riscv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin   // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through covers the distance-2 hazard
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// File: pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload is a bubble, valid field clear
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

// File: execute_stage.sv
module execute_stage (
    input  riscv_pkg::id_ex_t    ex_i,
    input  logic                 fwd_valid_i,
    input  riscv_pkg::reg_addr_t fwd_rd_i,
    input  riscv_pkg::xlen_t     fwd_data_i,
    output riscv_pkg::ex_wb_t    wb_o,
    output logic                 redirect_o,
    output riscv_pkg::xlen_t     redirect_pc_o,
    dmem_if.core                 dmem
);
    import riscv_pkg::*;

    logic  fwd_a;
    logic  fwd_b;
    logic  taken;
    xlen_t op_a;
    xlen_t rs2_val;
    xlen_t op_b;
    xlen_t alu_res;

    // bypass from writeback, x0 never forwarded
    assign fwd_a   = fwd_valid_i && (fwd_rd_i != '0) && (fwd_rd_i == ex_i.rs1_addr);
    assign fwd_b   = fwd_valid_i && (fwd_rd_i != '0) && (fwd_rd_i == ex_i.rs2_addr);
    assign op_a    = fwd_a ? fwd_data_i : ex_i.rs1_data;
    assign rs2_val = fwd_b ? fwd_data_i : ex_i.rs2_data;
    assign op_b    = ex_i.b_is_imm ? ex_i.imm : rs2_val;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign taken         = (op_a == rs2_val) ^ ex_i.br_ne;
    assign redirect_o    = ex_i.valid && (ex_i.is_jal || (ex_i.is_branch && taken));
    assign redirect_pc_o = ex_i.pc + ex_i.imm;   // same adder for branch and jal

    // data memory request, read data lands in writeback
    assign dmem.addr  = (ex_i.mem_read || ex_i.mem_write) ? alu_res : '0;
    assign dmem.wdata = rs2_val;
    assign dmem.wbe   = {4{ex_i.valid && ex_i.mem_write}};

    assign wb_o.alu_result = alu_res;
    assign wb_o.pc4        = ex_i.pc4;
    assign wb_o.rd         = ex_i.rd;
    assign wb_o.reg_write  = ex_i.reg_write;
    assign wb_o.wb_sel     = ex_i.wb_sel;
    assign wb_o.csr_write  = ex_i.csr_write;
    assign wb_o.csr_data   = op_a;               // csrw source is rs1
    assign wb_o.valid      = ex_i.valid;

endmodule

// File: sync_ram_wbe.sv
module sync_ram_wbe #(
    parameter int DEPTH = 1024
) (
    input logic    clk,
    dmem_if.memory mem
);
    import riscv_pkg::*;

    localparam int AW = $clog2(DEPTH);

    xlen_t ram [DEPTH];
    logic [AW-1:0] word_addr;

    assign word_addr = mem.addr[AW+1:2];   // word addressed

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem.wbe[i]) begin
                ram[word_addr][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
        end
        mem.rdata <= ram[word_addr];   // old word on a write cycle
    end

endmodule

// File: riscv_core_top.sv
module riscv_core_top #(
    parameter riscv_pkg::xlen_t RESET_PC   = 32'h0000_0000,
    parameter int               IMEM_DEPTH = 1024,
    parameter int               DMEM_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  riscv_pkg::xlen_t              imem_wdata_i,
    output riscv_pkg::xlen_t              csr_o,
    output logic                          csr_we_o
);
    import riscv_pkg::*;

    xlen_t     inst;
    xlen_t     pc;
    logic      inst_valid;
    logic      redirect;
    xlen_t     redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    id_ex_t    dec;
    id_ex_t    id_ex;
    ex_wb_t    ex_wb_d;
    ex_wb_t    ex_wb;
    xlen_t     wb_data;
    logic      rf_we;

    dmem_if dmem_bus ();

    fetch_stage #(
        .RESET_PC   (RESET_PC),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_stage_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .inst_o        (inst),
        .pc_o          (pc),
        .inst_valid_o  (inst_valid)
    );

    decode_stage decode_stage_i (
        .inst_i       (inst),
        .pc_i         (pc),
        .inst_valid_i (inst_valid),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .dec_o        (dec)
    );

    regfile_1w2r regfile_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (rf_we),
        .waddr_i  (ex_wb.rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    // redirect kills the instruction leaving decode
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (redirect),
        .d_i     (dec),
        .q_o     (id_ex)
    );

    execute_stage execute_stage_i (
        .ex_i          (id_ex),
        .fwd_valid_i   (rf_we),
        .fwd_rd_i      (ex_wb.rd),
        .fwd_data_i    (wb_data),
        .wb_o          (ex_wb_d),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .dmem          (dmem_bus)
    );

    pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg_i (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (1'b0),    // a redirecting instruction still retires
        .d_i     (ex_wb_d),
        .q_o     (ex_wb)
    );

    sync_ram_wbe #(.DEPTH(DMEM_DEPTH)) dmem_i (
        .clk (clk),
        .mem (dmem_bus)
    );

    // writeback select
    always_comb begin
        case (ex_wb.wb_sel)
            WB_MEM:  wb_data = dmem_bus.rdata;
            WB_PC4:  wb_data = ex_wb.pc4;
            default: wb_data = ex_wb.alu_result;
        endcase
    end

    assign rf_we    = ex_wb.valid && ex_wb.reg_write;
    assign csr_we_o = ex_wb.valid && ex_wb.csr_write;

    // tohost register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            csr_o <= '0;
        end else if (csr_we_o) begin
            csr_o <= ex_wb.csr_data;
        end
    end

endmodule

// File: riscv_core_assert.sv
module riscv_core_assert (
    input logic       clk,
    input logic       reset_i,
    input logic       redirect_i,
    input logic       dec_valid_i,
    input logic       dec_mem_write_i,
    input logic [3:0] wbe_i,
    input logic       csr_we_i
);

    int fail_count = 0;   // read by the testbench at the end

    // execute holds last cycle's decode output unless a redirect flushed it
    redirect_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |-> ($past(dec_valid_i) && !$past(redirect_i)))
    else begin
        $error("redirect raised while execute holds a bubble");
        fail_count++;
    end

    // byte enables only for a live store
    wbe_only_on_store: assert property (@(posedge clk) disable iff (reset_i)
        (wbe_i != 4'b0) |-> $past(dec_valid_i && dec_mem_write_i && !redirect_i))
    else begin
        $error("data memory write enable without a valid store");
        fail_count++;
    end

    // first reset edge clears ex_wb, so check from the second one
    no_csr_in_reset: assert property (@(posedge clk)
        (reset_i ##1 reset_i) |-> !csr_we_i)
    else begin
        $error("csr_we_o high during reset");
        fail_count++;
    end

endmodule

bind riscv_core_top riscv_core_assert core_checks_i (
    .clk             (clk),
    .reset_i         (reset_i),
    .redirect_i      (redirect),
    .dec_valid_i     (dec.valid),
    .dec_mem_write_i (dec.mem_write),
    .wbe_i           (dmem_bus.wbe),
    .csr_we_i        (csr_we_o)
);

// File: tb_riscv_core.sv
module tb_riscv_core;
    import riscv_pkg::*;

    localparam int IMEM_DEPTH   = 1024;
    localparam int DMEM_DEPTH   = 1024;
    localparam int AW           = $clog2(IMEM_DEPTH);
    localparam int CSR_TIMEOUT  = 200;   // cycles allowed between two CSR writes
    localparam int QUIET_CYCLES = 50;
    localparam int MAX_LINES    = 256;

    logic          clk;
    logic          reset;
    logic          imem_we;
    logic [AW-1:0] imem_addr;
    xlen_t         imem_wdata;
    xlen_t         csr_value;
    logic          csr_we;

    logic [AW-1:0] prog_addr [$];
    xlen_t         prog_word [$];
    string         test_name [$];
    xlen_t         test_exp [$];
    int            errors;
    int            passed;
    bit            timed_out;

    riscv_core_top #(
        .RESET_PC   (32'h0000_0000),
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) riscv_core_top_i (
        .clk          (clk),
        .reset_i      (reset),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .csr_o        (csr_value),
        .csr_we_o     (csr_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // P lines go to the loader, E lines are the expected tohost values
    task automatic read_stim(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] addr;
        xlen_t       word;
        ok = 1'b0;
        fd = $fopen("program_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        for (int i = 0; i < MAX_LINES; i++) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0) continue;
            if (line.getc(0) == "P") begin
                n = $sscanf(line, "P %h %h", addr, word);
                if (n == 2) begin
                    prog_addr.push_back(addr[AW-1:0]);
                    prog_word.push_back(word);
                end
            end else if (line.getc(0) == "E") begin
                n = $sscanf(line, "E %s %h", name, word);
                if (n == 2) begin
                    test_name.push_back(name);
                    test_exp.push_back(word);
                end
            end
        end
        $fclose(fd);
        ok = (prog_word.size() > 0) && (test_name.size() > 0);
    endtask

    task automatic load_program();
        int idle;
        for (int i = 0; i < prog_word.size(); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= prog_addr[i];
            imem_wdata <= prog_word[i];
            idle = $urandom_range(2);   // random gaps on the loader port
            repeat (idle) begin
                @(posedge clk);
                imem_we <= 1'b0;
            end
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic wait_csr_write(output bit seen);
        int cycles;
        cycles = 0;
        while (!csr_we && cycles < CSR_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        seen = csr_we;
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t test %s: csr_o is %h, expected %h", $time, name, got, exp);
            errors++;
        end else begin
            $display("ok   %s csr_o %h", name, got);
            passed++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t test %s: value is %b, expected %b", $time, name, got, exp);
            errors++;
        end else begin
            $display("ok   %s %b", name, got);
            passed++;
        end
    endtask

    initial begin
        bit stim_ok;
        bit seen;
        int stray;
        int assert_fails;
        errors     = 0;
        passed     = 0;
        timed_out  = 1'b0;
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        void'($urandom(34));
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("could not read program or expected values from program_stim.txt");
            errors++;
        end else begin
            load_program();   // core held in reset while imem fills
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            check_bit("reset_csr_we", csr_we, 1'b0);
            check_word("reset_csr", csr_value, '0);
            for (int t = 0; t < test_name.size(); t++) begin
                wait_csr_write(seen);
                if (!seen) begin
                    $display("no CSR write arrived for test %s within %0d cycles",
                             test_name[t], CSR_TIMEOUT);
                    errors++;
                    timed_out = 1'b1;
                    break;
                end
                @(negedge clk);   // new value shows one cycle after the pulse
                check_word(test_name[t], csr_value, test_exp[t]);
            end
            if (!timed_out) begin
                // program ends in a self loop, flushed shadows must stay quiet
                stray = 0;
                for (int c = 0; c < QUIET_CYCLES; c++) begin
                    @(negedge clk);
                    if (csr_we) stray++;
                end
                if (stray != 0) begin
                    $display("test no_stray_write: %0d CSR writes after the last expected one",
                             stray);
                    errors++;
                end else begin
                    $display("ok   no_stray_write");
                    passed++;
                end
            end
        end
        assert_fails = riscv_core_top_i.core_checks_i.fail_count;
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: program_stim.txt
# P <word index hex> <instruction hex>  program word for the imem loader
# E <test name> <expected csr hex>       tohost values in program order
P 00 12300093
P 01 12345137
P 02 002081b3
P 03 51e19073
P 04 40208233
P 05 51e21073
P 06 0041c2b3
P 07 0032f333
P 08 001363b3
P 09 00122433
P 0a 008384b3
P 0b 51e49073
P 0c 04702023
P 0d 04002503
P 0e 01050593
P 0f 51e59073
P 10 00500013
P 11 00100633
P 12 51e61073
P 13 00c08663
P 14 51e11073
P 15 51e19073
P 16 00c09463
P 17 07a00693
P 18 00169663
P 19 51e21073
P 1a 51e29073
P 1b 00168463
P 1c 51e69073
P 1d 00c0076f
P 1e 51e11073
P 1f 51e19073
P 20 51e71073
P 21 0000006f
E add_fwd 12345123
E sub edcbb123
E alu_logic_slt 12344124
E store_load 12344133
E x0_write 00000123
E branches 0000007a
E jal_link 00000078

// File: verilog.f
riscv_pkg.sv
dmem_if.sv
fetch_stage.sv
decode_stage.sv
regfile_1w2r.sv
pipe_reg.sv
execute_stage.sv
sync_ram_wbe.sv
riscv_core_top.sv
riscv_core_assert.sv
tb_riscv_core.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - riscv_pkg.sv
  - dmem_if.sv
  - fetch_stage.sv
  - decode_stage.sv
  - regfile_1w2r.sv
  - pipe_reg.sv
  - execute_stage.sv
  - sync_ram_wbe.sv
  - riscv_core_top.sv
  - target: test
    files:
      - riscv_core_assert.sv
      - tb_riscv_core.sv
